/* flist.f */
hdl/prach_oran_pkg.sv
hdl/prach_fifo_if.sv
hdl/prach_sample_router.sv
hdl/prach_fifo.sv
hdl/prach_oran_packer.sv
hdl/prach_alarm_counter.sv
hdl/prach_oran_alarm.sv
hdl/prach_oran_top.sv
verification/prach_oran_clk_gen.sv
verification/prach_oran_assert.sv
verification/prach_oran_tb.sv

/* Bender.yml */
package:
  name: prach_oran

sources:
  - files:
      - hdl/prach_oran_pkg.sv
      - hdl/prach_fifo_if.sv
      - hdl/prach_sample_router.sv
      - hdl/prach_fifo.sv
      - hdl/prach_oran_packer.sv
      - hdl/prach_alarm_counter.sv
      - hdl/prach_oran_alarm.sv
      - hdl/prach_oran_top.sv
  - target: test
    files:
      - verification/prach_oran_clk_gen.sv
      - verification/prach_oran_assert.sv
      - verification/prach_oran_tb.sv

/* verification/prach_oran_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module prach_oran_tb
  import prach_oran_pkg::*;
();

  localparam int NUM_ANT      = 4;
  localparam int ALARM_CNT_W  = 4;
  localparam int FIFO_DEPTH   = 16;
  localparam int CPLANE_DEPTH = 4;
  localparam int THRESH       = 20;
  localparam int CNT_MAX      = (1 << ALARM_CNT_W) - 1;
  localparam int PERIOD_NS    = 100;
  localparam int BEAT_TIMEOUT = 200;  // Cycles without a beat before giving up.

  // Rough cycle budget per test, summed for the watchdog.
  localparam int SECTION_CYCLES = 400;
  localparam int STALL_CYCLES   = 250;
  localparam int CPLANE_CYCLES  = 250;
  localparam int CLEAR_CYCLES   = 60;
  localparam int TEST_CYCLES    = 16 + 3 * SECTION_CYCLES + STALL_CYCLES + CPLANE_CYCLES
                                  + CLEAR_CYCLES;
  localparam int MARGIN_CYCLES  = 1000;

  typedef logic [ALARM_CNT_W-1:0] count_t;

  wire                             clk;
  wire                             rst_n_i;
  logic                            sample_vld_i;
  logic [$clog2(NUM_ANT)-1:0]      sample_ant_i;
  iq_sample_t                      sample_data_i;
  logic                            cplane_vld_i;
  sec_len_t                        cplane_len_i;
  logic                            oran_tvalid_o;
  iq_sample_t                      oran_tdata_o;
  logic                            oran_tlast_o;
  logic                            oran_tready_i;
  logic                            alarm_clear_i;
  count_t                          vld_cnt;
  count_t                          cpl_cnt;
  logic [NUM_ANT-1:0][ALARM_CNT_W-1:0] ant_cnt;

  integer     seed = 52217;
  int         value_errs = 0;
  int         other_errs = 0;
  iq_sample_t exp_q [$];

  // Expected alarm counts, kept by the rules of the alarm block.
  count_t                              mdl_vld = '0;
  count_t                              mdl_cpl = '0;
  logic [NUM_ANT-1:0][ALARM_CNT_W-1:0] mdl_ant = '0;

  prach_oran_clk_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(16)) u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n_i)
  );

  prach_oran_top #(
    .NUM_ANT(NUM_ANT), .ALARM_CNT_W(ALARM_CNT_W), .FIFO_DEPTH(FIFO_DEPTH),
    .CPLANE_DEPTH(CPLANE_DEPTH), .VLD_WO_RDY_THRESH(THRESH)
  ) DUT (
    .clk(clk), .rst_n_i(rst_n_i),
    .sample_vld_i(sample_vld_i), .sample_ant_i(sample_ant_i), .sample_data_i(sample_data_i),
    .cplane_vld_i(cplane_vld_i), .cplane_len_i(cplane_len_i),
    .oran_tvalid_o(oran_tvalid_o), .oran_tdata_o(oran_tdata_o),
    .oran_tlast_o(oran_tlast_o), .oran_tready_i(oran_tready_i),
    .alarm_clear_i(alarm_clear_i),
    .vld_wo_rdy_err_cnt_o(vld_cnt), .cplane_fifo_ovfl_err_cnt_o(cpl_cnt),
    .prach_fifo_ovfl_err_cnt_o(ant_cnt)
  );

  task automatic compare_sample(input iq_sample_t act, input iq_sample_t exp_val,
                                input string what);
    if (act !== exp_val) begin
      value_errs++;
      $display("FAILED at %0t: %s got %h, expected %h", $time, what, act, exp_val);
    end
  endtask

  task automatic compare_last(input logic act, input logic exp_val, input string what);
    if (act !== exp_val) begin
      value_errs++;
      $display("FAILED at %0t: %s got %b, expected %b", $time, what, act, exp_val);
    end
  endtask

  task automatic compare_count(input count_t act, input count_t exp_val, input string what);
    if (act !== exp_val) begin
      value_errs++;
      $display("FAILED at %0t: %s got %0d, expected %0d", $time, what, act, exp_val);
    end
  endtask

  function automatic count_t sat_add(input count_t c, input int n);
    int sum;
    sum = int'(c) + n;
    return (sum > CNT_MAX) ? count_t'(CNT_MAX) : count_t'(sum);
  endfunction

  // Section id, antenna and index make every sample unique.
  function automatic iq_sample_t make_sample(input int sec, input int ant, input int idx);
    return {8'(sec), 8'(ant), 16'(idx)};
  endfunction

  task automatic check_counts();
    compare_count(vld_cnt, mdl_vld, "valid-without-ready count");
    compare_count(cpl_cnt, mdl_cpl, "C-plane overflow count");
    for (int a = 0; a < NUM_ANT; a++) begin
      compare_count(ant_cnt[a], mdl_ant[a], $sformatf("antenna %0d overflow count", a));
    end
  endtask

  // Tasks below start and end on a falling edge.
  task automatic push_sample(input int ant, input iq_sample_t data);
    sample_vld_i  = 1'b1;
    sample_ant_i  = ant[$clog2(NUM_ANT)-1:0];
    sample_data_i = data;
    @(negedge clk);
    sample_vld_i = 1'b0;
  endtask

  task automatic push_request(input int len);
    cplane_vld_i = 1'b1;
    cplane_len_i = sec_len_t'(len);
    @(negedge clk);
    cplane_vld_i = 1'b0;
  endtask

  // Ready is chosen at the falling edge, so a beat seen here transfers at the next rise.
  task automatic receive_beats(input int n, input bit random_ready);
    int         got;
    int         idle;
    int         low_run;
    logic       rdy;
    iq_sample_t exp_beat;
    got = 0;
    idle = 0;
    low_run = 0;
    while (got < n && idle < BEAT_TIMEOUT) begin
      rdy = 1'b1;
      if (random_ready && low_run < 3) rdy = 1'($random(seed) & 1);  // Stalls stay short.
      low_run = rdy ? 0 : low_run + 1;
      oran_tready_i = rdy;
      if (oran_tvalid_o && rdy) begin
        exp_beat = exp_q.pop_front();
        compare_sample(oran_tdata_o, exp_beat, $sformatf("beat %0d data", got));
        compare_last(oran_tlast_o, got == n - 1, $sformatf("beat %0d tlast", got));
        got++;
        idle = 0;
      end else begin
        idle++;
      end
      @(negedge clk);
    end
    oran_tready_i = 1'b1;
    if (got < n) begin
      other_errs++;
      $display("Stream stopped: only %0d of %0d beats arrived", got, n);
    end
  endtask

  task automatic take_beat(input int stall, input iq_sample_t exp_beat, input logic exp_last);
    int waited;
    waited = 0;
    oran_tready_i = 1'b0;
    while (!oran_tvalid_o && waited < BEAT_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!oran_tvalid_o) begin
      other_errs++;
      $display("No beat appeared while the stream was stalled");
    end else begin
      repeat (stall) @(negedge clk);
      compare_sample(oran_tdata_o, exp_beat, "stalled beat data");
      compare_last(oran_tlast_o, exp_last, "stalled beat tlast");
      oran_tready_i = 1'b1;
      @(negedge clk);
      oran_tready_i = 1'b0;
    end
  endtask

  task automatic test_reset();
    compare_last(oran_tvalid_o, 1'b0, "tvalid after reset");
    check_counts();
  endtask

  task automatic test_section(input int sec, input int len, input bit random_ready);
    for (int a = 0; a < NUM_ANT; a++) begin
      for (int i = 0; i < len; i++) begin
        push_sample(a, make_sample(sec, a, i));
        exp_q.push_back(make_sample(sec, a, i));
      end
    end
    push_request(len);
    receive_beats(NUM_ANT * len, random_ready);
  endtask

  task automatic test_sample_overflow(input int n);
    for (int i = 0; i < FIFO_DEPTH + n; i++) begin
      push_sample(0, make_sample(3, 0, i));
      if (i < FIFO_DEPTH) exp_q.push_back(make_sample(3, 0, i));
    end
    repeat (8) @(negedge clk);
    mdl_ant[0] = sat_add(mdl_ant[0], n);
    check_counts();
    for (int a = 1; a < NUM_ANT; a++) begin
      for (int i = 0; i < FIFO_DEPTH; i++) begin
        push_sample(a, make_sample(3, a, i));
        exp_q.push_back(make_sample(3, a, i));
      end
    end
    push_request(FIFO_DEPTH);
    receive_beats(NUM_ANT * FIFO_DEPTH, 1'b0);
  endtask

  task automatic test_stall();
    for (int a = 0; a < NUM_ANT; a++) push_sample(a, make_sample(4, a, 0));
    push_request(1);
    take_beat(10, make_sample(4, 0, 0), 1'b0);
    repeat (6) @(negedge clk);
    check_counts();  // A short stall must not count.
    take_beat(THRESH + 20, make_sample(4, 1, 0), 1'b0);
    take_beat(THRESH + 20, make_sample(4, 2, 0), 1'b0);
    take_beat(0, make_sample(4, 3, 0), 1'b1);
    oran_tready_i = 1'b1;
    repeat (10) @(negedge clk);
    mdl_vld = sat_add(mdl_vld, 2);
    check_counts();
  endtask

  // The packer takes one request and then waits for samples on antenna 0.
  task automatic test_cplane_overflow(input int m);
    push_request(1);
    repeat (6) @(negedge clk);
    for (int i = 0; i < CPLANE_DEPTH + m; i++) push_request(2);
    repeat (8) @(negedge clk);
    mdl_cpl = sat_add(mdl_cpl, m);
    check_counts();
    for (int i = 0; i < 20; i++) push_request(2);
    for (int a = 1; a < NUM_ANT; a++) begin
      for (int i = 0; i < FIFO_DEPTH + 20; i++) push_sample(a, make_sample(5, a, i));
      mdl_ant[a] = sat_add(mdl_ant[a], 20);
    end
    repeat (8) @(negedge clk);
    mdl_cpl = sat_add(mdl_cpl, 20);
    check_counts();
  endtask

  task automatic test_clear();
    int k;
    alarm_clear_i = 1'b1;
    @(negedge clk);
    alarm_clear_i = 1'b0;
    k = 1;
    while ((vld_cnt != '0 || cpl_cnt != '0 || ant_cnt != '0) && k < 10) begin
      @(negedge clk);
      k++;
    end
    if (vld_cnt != '0 || cpl_cnt != '0 || ant_cnt != '0) begin
      other_errs++;
      $display("Alarm counts were not cleared within 10 cycles");
    end
    mdl_vld = '0;
    mdl_cpl = '0;
    mdl_ant = '0;
    check_counts();
    alarm_clear_i = 1'b1;  // A held clear must not block new counts.
    repeat (12) @(negedge clk);
    check_counts();
    push_sample(1, make_sample(6, 1, 0));
    push_sample(1, make_sample(6, 1, 1));
    repeat (8) @(negedge clk);
    mdl_ant[1] = sat_add(mdl_ant[1], 2);
    check_counts();
    alarm_clear_i = 1'b0;
  endtask

  initial begin
    #((TEST_CYCLES + MARGIN_CYCLES) * PERIOD_NS);
    $display("Watchdog expired before the tests finished");
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    sample_vld_i  = 1'b0;
    sample_ant_i  = '0;
    sample_data_i = '0;
    cplane_vld_i  = 1'b0;
    cplane_len_i  = '0;
    oran_tready_i = 1'b1;
    alarm_clear_i = 1'b0;
    wait (rst_n_i === 1'b1);
    @(negedge clk);
    test_reset();
    test_section(1, 8, 1'b0);
    test_section(2, 8, 1'b1);
    test_sample_overflow(4);
    test_stall();
    test_cplane_overflow(3);
    test_clear();
    $display("Errors: value %0d, other %0d, assertion %0d",
             value_errs, other_errs, DUT.u_assert.fail_cnt);
    if (value_errs == 0 && other_errs == 0 && DUT.u_assert.fail_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/prach_oran_assert.sv */
`timescale 1ns/100ps
`default_nettype none

module prach_oran_assert
  import prach_oran_pkg::*;
(
  input wire        clk,
  input wire        rst_n_i,
  input wire        oran_tvalid_o,
  input iq_sample_t oran_tdata_o,
  input wire        oran_tlast_o,
  input wire        oran_tready_i
);

  int unsigned fail_cnt = 0;  // Read by the testbench at the end of the run.

  // A stalled beat keeps valid and data until it is taken.
  a_stall_stable : assert property (@(posedge clk) disable iff (!rst_n_i)
    (oran_tvalid_o && !oran_tready_i) |=> (oran_tvalid_o && $stable(oran_tdata_o)))
    else begin
      fail_cnt++;
      $error("tvalid or tdata changed while the stream was stalled");
    end

  a_reset_idle : assert property (@(posedge clk)
    !rst_n_i |=> (!oran_tvalid_o && !oran_tlast_o))
    else begin
      fail_cnt++;
      $error("stream not idle after reset");
    end

  a_last_valid : assert property (@(posedge clk) disable iff (!rst_n_i)
    oran_tlast_o |-> oran_tvalid_o)
    else begin
      fail_cnt++;
      $error("tlast seen without tvalid");
    end

endmodule

bind prach_oran_top prach_oran_assert u_assert (
  .clk           (clk),
  .rst_n_i       (rst_n_i),
  .oran_tvalid_o (oran_tvalid_o),
  .oran_tdata_o  (oran_tdata_o),
  .oran_tlast_o  (oran_tlast_o),
  .oran_tready_i (oran_tready_i)
);

`default_nettype wire

/* verification/prach_oran_clk_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module prach_oran_clk_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 16
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset is released on a falling edge, away from the sampling edge.
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

/* hdl/prach_oran_top.sv */
`timescale 1ns/100ps
`default_nettype none

module prach_oran_top
  import prach_oran_pkg::*;
#(
  parameter int NUM_ANT           = 4,
  parameter int ALARM_CNT_W       = 4,
  parameter int FIFO_DEPTH        = 16,
  parameter int CPLANE_DEPTH      = 4,
  parameter int VLD_WO_RDY_THRESH = 500
) (
  input  wire                                 clk,
  input  wire                                 rst_n_i,
  input  wire                                 sample_vld_i,
  input  wire  [$clog2(NUM_ANT)-1:0]          sample_ant_i,
  input  iq_sample_t                          sample_data_i,
  input  wire                                 cplane_vld_i,
  input  sec_len_t                            cplane_len_i,
  output logic                                oran_tvalid_o,
  output iq_sample_t                          oran_tdata_o,
  output logic                                oran_tlast_o,
  input  wire                                 oran_tready_i,
  input  wire                                 alarm_clear_i,
  output logic [ALARM_CNT_W-1:0]              vld_wo_rdy_err_cnt_o,
  output logic [ALARM_CNT_W-1:0]              cplane_fifo_ovfl_err_cnt_o,
  output logic [NUM_ANT-1:0][ALARM_CNT_W-1:0] prach_fifo_ovfl_err_cnt_o
);

  prach_fifo_if #(.WIDTH($bits(iq_sample_t))) ant_if [NUM_ANT] ();
  prach_fifo_if #(.WIDTH($bits(sec_len_t)))   cplane_if ();

  prach_sample_router #(.NUM_ANT(NUM_ANT)) u_router (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .sample_vld_i  (sample_vld_i),
    .sample_ant_i  (sample_ant_i),
    .sample_data_i (sample_data_i),
    .cplane_vld_i  (cplane_vld_i),
    .cplane_len_i  (cplane_len_i),
    .ant_fifo      (ant_if),
    .cplane_fifo   (cplane_if)
  );

  for (genvar a = 0; a < NUM_ANT; a++) begin : g_ant_fifo
    prach_fifo #(.WIDTH($bits(iq_sample_t)), .DEPTH(FIFO_DEPTH)) u_fifo (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .port    (ant_if[a])
    );
  end

  prach_fifo #(.WIDTH($bits(sec_len_t)), .DEPTH(CPLANE_DEPTH)) u_cplane_fifo (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .port    (cplane_if)
  );

  prach_oran_packer #(.NUM_ANT(NUM_ANT)) u_packer (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .ant_fifo      (ant_if),
    .cplane_fifo   (cplane_if),
    .oran_tvalid_o (oran_tvalid_o),
    .oran_tdata_o  (oran_tdata_o),
    .oran_tlast_o  (oran_tlast_o),
    .oran_tready_i (oran_tready_i)
  );

  // The alarm block watches the stream as it leaves the packer.
  prach_oran_alarm #(
    .NUM_ANT           (NUM_ANT),
    .ALARM_CNT_W       (ALARM_CNT_W),
    .VLD_WO_RDY_THRESH (VLD_WO_RDY_THRESH)
  ) u_alarm (
    .clk                        (clk),
    .rst_n_i                    (rst_n_i),
    .clear_i                    (alarm_clear_i),
    .oran_tvalid_i              (oran_tvalid_o),
    .oran_tready_i              (oran_tready_i),
    .ant_fifo                   (ant_if),
    .cplane_fifo                (cplane_if),
    .vld_wo_rdy_err_cnt_o       (vld_wo_rdy_err_cnt_o),
    .cplane_fifo_ovfl_err_cnt_o (cplane_fifo_ovfl_err_cnt_o),
    .prach_fifo_ovfl_err_cnt_o  (prach_fifo_ovfl_err_cnt_o)
  );

endmodule

`default_nettype wire

/* hdl/prach_oran_alarm.sv */
`timescale 1ns/100ps
`default_nettype none

module prach_oran_alarm
  import prach_oran_pkg::*;
#(
  parameter int NUM_ANT           = 4,
  parameter int ALARM_CNT_W       = 4,
  parameter int VLD_WO_RDY_THRESH = 500
) (
  input  wire                                    clk,
  input  wire                                    rst_n_i,
  input  wire                                    clear_i,
  input  wire                                    oran_tvalid_i,
  input  wire                                    oran_tready_i,
  prach_fifo_if.monitor                          ant_fifo [NUM_ANT],
  prach_fifo_if.monitor                          cplane_fifo,
  output logic [ALARM_CNT_W-1:0]                 vld_wo_rdy_err_cnt_o,
  output logic [ALARM_CNT_W-1:0]                 cplane_fifo_ovfl_err_cnt_o,
  output logic [NUM_ANT-1:0][ALARM_CNT_W-1:0]    prach_fifo_ovfl_err_cnt_o
);

  localparam int FANOUT_DEPTH = 4;
  localparam int VLD_W        = $clog2(VLD_WO_RDY_THRESH + 1);  // Top value exceeds the threshold.

  logic                                clear_0;
  logic                                clear_1;
  logic                                clear_rise;
  logic [NUM_ANT-1:0][FANOUT_DEPTH-1:0] clear_fan;

  logic                   tvalid_q;
  logic                   tready_q;
  logic [VLD_W-1:0]       vld_wo_rdy_count;
  logic                   vld_wo_rdy_err;
  logic                   vld_wo_rdy_err_d;
  logic                   vld_wo_rdy_strb;
  logic [ALARM_CNT_W-1:0] vld_wo_rdy_cnt;

  logic                   cplane_ovfl_q;
  logic [ALARM_CNT_W-1:0] cplane_ovfl_cnt;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      clear_0          <= 1'b0;
      clear_1          <= 1'b0;
      clear_rise       <= 1'b0;
      clear_fan        <= '0;
      tvalid_q         <= 1'b0;
      tready_q         <= 1'b0;
      vld_wo_rdy_count <= '0;
      vld_wo_rdy_err   <= 1'b0;
      vld_wo_rdy_err_d <= 1'b0;
      vld_wo_rdy_strb  <= 1'b0;
      cplane_ovfl_q    <= 1'b0;
      vld_wo_rdy_err_cnt_o       <= '0;
      cplane_fifo_ovfl_err_cnt_o <= '0;
    end else begin
      clear_0    <= clear_i;
      clear_1    <= clear_0;
      clear_rise <= clear_0 && !clear_1;  // A held clear acts once.
      for (int k = 0; k < NUM_ANT; k++) begin
        clear_fan[k] <= {clear_fan[k][FANOUT_DEPTH-2:0], clear_rise};
      end

      tvalid_q <= oran_tvalid_i;
      tready_q <= oran_tready_i;

      // Consecutive stalled cycles. The counter parks at its top value.
      if (!tvalid_q || tready_q) begin
        vld_wo_rdy_count <= '0;
      end else if (!(&vld_wo_rdy_count)) begin
        vld_wo_rdy_count <= vld_wo_rdy_count + 1'b1;
      end
      vld_wo_rdy_err   <= (vld_wo_rdy_count >= VLD_W'(VLD_WO_RDY_THRESH));
      vld_wo_rdy_err_d <= vld_wo_rdy_err;
      vld_wo_rdy_strb  <= vld_wo_rdy_err && !vld_wo_rdy_err_d;  // One per stall episode.

      cplane_ovfl_q <= cplane_fifo.overflow;

      vld_wo_rdy_err_cnt_o       <= vld_wo_rdy_cnt;
      cplane_fifo_ovfl_err_cnt_o <= cplane_ovfl_cnt;
    end
  end

  prach_alarm_counter #(.CNT_W(ALARM_CNT_W)) u_vld_wo_rdy_cnt (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .alarm_i (vld_wo_rdy_strb),
    .clear_i (clear_fan[0][FANOUT_DEPTH-1]),
    .count_o (vld_wo_rdy_cnt)
  );

  prach_alarm_counter #(.CNT_W(ALARM_CNT_W)) u_cplane_ovfl_cnt (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .alarm_i (cplane_ovfl_q),
    .clear_i (clear_fan[0][FANOUT_DEPTH-1]),
    .count_o (cplane_ovfl_cnt)
  );

  for (genvar a = 0; a < NUM_ANT; a++) begin : g_ant_ovfl
    logic                   ovfl_q;
    logic [ALARM_CNT_W-1:0] ovfl_cnt;

    always_ff @(posedge clk) begin
      if (!rst_n_i) begin
        ovfl_q                       <= 1'b0;
        prach_fifo_ovfl_err_cnt_o[a] <= '0;
      end else begin
        ovfl_q                       <= ant_fifo[a].overflow;
        prach_fifo_ovfl_err_cnt_o[a] <= ovfl_cnt;
      end
    end

    // Each antenna has its own copy of the clear pipeline.
    prach_alarm_counter #(.CNT_W(ALARM_CNT_W)) u_ovfl_cnt (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .alarm_i (ovfl_q),
      .clear_i (clear_fan[a][FANOUT_DEPTH-1]),
      .count_o (ovfl_cnt)
    );
  end

endmodule

`default_nettype wire

/* hdl/prach_alarm_counter.sv */
`timescale 1ns/100ps
`default_nettype none

module prach_alarm_counter #(
  parameter int CNT_W = 4
) (
  input  wire              clk,
  input  wire              rst_n_i,
  input  wire              alarm_i,
  input  wire              clear_i,
  output logic [CNT_W-1:0] count_o
);

  // Clear wins over a coincident alarm. The count sticks at all-ones.
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      count_o <= '0;
    end else if (clear_i) begin
      count_o <= '0;
    end else if (alarm_i && !(&count_o)) begin
      count_o <= count_o + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* hdl/prach_oran_packer.sv */
`timescale 1ns/100ps
`default_nettype none

module prach_oran_packer
  import prach_oran_pkg::*;
#(
  parameter int NUM_ANT = 4
) (
  input  wire             clk,
  input  wire             rst_n_i,
  prach_fifo_if.consumer  ant_fifo [NUM_ANT],
  prach_fifo_if.consumer  cplane_fifo,
  output logic            oran_tvalid_o,
  output iq_sample_t      oran_tdata_o,
  output logic            oran_tlast_o,
  input  wire             oran_tready_i
);

  localparam int ANT_W = (NUM_ANT > 1) ? $clog2(NUM_ANT) : 1;

  pack_state_t        state;
  sec_len_t           sec_len;
  sec_len_t           beat_cnt;
  logic [ANT_W-1:0]   ant_sel;
  iq_sample_t         ant_data [NUM_ANT];
  logic [NUM_ANT-1:0] ant_empty;
  logic [NUM_ANT-1:0] ant_pop;
  logic               load;
  logic               last_beat;
  logic               last_ant;

  // Per-antenna FIFO signals gathered into arrays that ant_sel can index.
  for (genvar a = 0; a < NUM_ANT; a++) begin : g_ant
    assign ant_data[a]    = ant_fifo[a].pop_data;
    assign ant_empty[a]   = ant_fifo[a].empty;
    assign ant_fifo[a].pop = ant_pop[a];
  end

  assign last_beat = (beat_cnt == sec_len - 1'b1);
  assign last_ant  = (ant_sel == ANT_W'(NUM_ANT-1));

  // A new beat is taken only when the output register is free or draining.
  assign load = (state == PACK_SEND) && !ant_empty[ant_sel] && (!oran_tvalid_o || oran_tready_i);

  always_comb begin
    ant_pop = '0;
    if (load) ant_pop[ant_sel] = 1'b1;
  end

  assign cplane_fifo.pop = (state == PACK_IDLE) && !cplane_fifo.empty;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state         <= PACK_IDLE;
      ant_sel       <= '0;
      beat_cnt      <= '0;
      oran_tvalid_o <= 1'b0;
      oran_tlast_o  <= 1'b0;
    end else begin
      if (oran_tvalid_o && oran_tready_i) begin
        oran_tvalid_o <= 1'b0;
        oran_tlast_o  <= 1'b0;
      end
      if (load) begin
        oran_tvalid_o <= 1'b1;
        oran_tlast_o  <= last_beat && last_ant;  // Only the final beat of the section.
        beat_cnt      <= beat_cnt + 1'b1;
      end
      case (state)
        PACK_IDLE: begin
          if (!cplane_fifo.empty && (cplane_fifo.pop_data != '0)) begin
            ant_sel  <= '0;
            beat_cnt <= '0;
            state    <= PACK_SEND;
          end
        end
        PACK_SEND: if (load && last_beat) state <= PACK_NEXT;
        PACK_NEXT: begin
          beat_cnt <= '0;
          ant_sel  <= ant_sel + 1'b1;
          state    <= last_ant ? PACK_IDLE : PACK_SEND;
        end
        default: state <= PACK_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (cplane_fifo.pop) sec_len <= cplane_fifo.pop_data;
    if (load) oran_tdata_o <= ant_data[ant_sel];
  end

endmodule

`default_nettype wire

/* hdl/prach_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module prach_fifo
  import prach_oran_pkg::*;
#(
  parameter int WIDTH = 32,
  parameter int DEPTH = 16
) (
  input  wire          clk,
  input  wire          rst_n_i,
  prach_fifo_if.buffer port
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             full;
  logic             do_push;
  logic             do_pop;

  assign full    = (count == (PTR_W+1)'(DEPTH));
  assign do_pop  = port.pop && !port.empty;
  assign do_push = port.push && (!full || do_pop);  // A pop frees the slot in the same cycle.

  assign port.empty    = (count == '0);
  assign port.pop_data = mem[rd_ptr];  // First-word fall-through.
  assign port.overflow = port.push && !do_push;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // A rejected push leaves the storage untouched.
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= port.push_data;
    end
  end

endmodule

`default_nettype wire

/* hdl/prach_sample_router.sv */
`timescale 1ns/100ps
`default_nettype none

module prach_sample_router
  import prach_oran_pkg::*;
#(
  parameter int NUM_ANT = 4
) (
  input  wire                         clk,
  input  wire                         rst_n_i,
  input  wire                         sample_vld_i,
  input  wire [$clog2(NUM_ANT)-1:0]   sample_ant_i,
  input  iq_sample_t                  sample_data_i,
  input  wire                         cplane_vld_i,
  input  sec_len_t                    cplane_len_i,
  prach_fifo_if.producer              ant_fifo [NUM_ANT],
  prach_fifo_if.producer              cplane_fifo
);

  localparam int ANT_W = $clog2(NUM_ANT);

  logic             sample_vld_q;
  logic [ANT_W-1:0] sample_ant_q;
  iq_sample_t       sample_data_q;
  logic             cplane_vld_q;
  sec_len_t         cplane_len_q;

  // Strobes are registered once so the pushes leave from flops.
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      sample_vld_q <= 1'b0;
      cplane_vld_q <= 1'b0;
    end else begin
      sample_vld_q <= sample_vld_i;
      cplane_vld_q <= cplane_vld_i;
    end
    sample_ant_q  <= sample_ant_i;
    sample_data_q <= sample_data_i;
    cplane_len_q  <= cplane_len_i;
  end

  // One-hot decode of the antenna index.
  for (genvar a = 0; a < NUM_ANT; a++) begin : g_ant_push
    assign ant_fifo[a].push      = sample_vld_q && (sample_ant_q == ANT_W'(a));
    assign ant_fifo[a].push_data = sample_data_q;
  end

  assign cplane_fifo.push      = cplane_vld_q && (cplane_len_q != '0);  // Empty sections dropped.
  assign cplane_fifo.push_data = cplane_len_q;

endmodule

`default_nettype wire

/* hdl/prach_fifo_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface prach_fifo_if #(
  parameter int WIDTH = 32
);

  logic             push;
  logic [WIDTH-1:0] push_data;
  logic             pop;
  logic [WIDTH-1:0] pop_data;   // Valid while empty is low.
  logic             empty;
  logic             overflow;   // One-cycle strobe on a push into a full FIFO.

  modport producer (output push, output push_data);

  modport buffer (
    input  push,
    input  push_data,
    input  pop,
    output pop_data,
    output empty,
    output overflow
  );

  modport consumer (output pop, input pop_data, input empty);

  modport monitor (input overflow);

endinterface

`default_nettype wire

/* hdl/prach_oran_pkg.sv */
`default_nettype none

package prach_oran_pkg;

  // One PRACH sample with I in the upper half and Q in the lower half.
  typedef logic [31:0] iq_sample_t;

  // Samples per antenna in one C-plane section. Zero means no section.
  typedef logic [7:0] sec_len_t;

  // Packer FSM states.
  typedef enum logic [1:0] {
    PACK_IDLE = 2'd0,  // Waiting for a C-plane section length.
    PACK_SEND = 2'd1,  // Moving samples of the current antenna.
    PACK_NEXT = 2'd2   // Stepping to the next antenna.
  } pack_state_t;

endpackage

`default_nettype wire
